// ==== vlog.f ====
+incdir+rtl
rtl/mv_pkg.sv
rtl/mv_ctrl.sv
rtl/mv_lanes.sv
rtl/mv_reduce.sv
rtl/matvec8.sv
tests/matvec8_props.sv
tests/matvec8_tb.sv

// ==== tests/matvec8_tb.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module matvec8_tb
    import mv_pkg::*;
();

    localparam int N_TESTS     = 7;
    localparam int MAT_WORDS   = `MV_N * `MV_N;
    localparam int CYCLE_LIMIT = N_TESTS * 400;

    logic     clk = 1'b0;
    logic     reset;
    logic     input_valid;
    mv_data_t input_data;
    logic     new_matrix;
    logic     output_ready;
    logic     input_ready;
    logic     output_valid;
    mv_sum_t  output_data;

    // test table
    string  test_name    [N_TESTS];
    bit     test_new_mat [N_TESTS];
    int     test_mat     [N_TESTS][MAT_WORDS];
    int     test_vec     [N_TESTS][`MV_N];
    int     test_gap     [N_TESTS];
    int     test_stall   [N_TESTS];
    longint test_exp     [N_TESTS][`MV_N];

    int seed;
    int errors;
    int checked;
    int outstanding;
    int jobs_loaded;
    int out_test;
    int cycle_count;
    bit reset_done;
    bit collect_done;

    matvec8 u_dut (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_data   (input_data),
        .new_matrix   (new_matrix),
        .output_ready (output_ready),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_data  (output_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // percentage roll, 0 to 99
    function automatic int roll();
        return {$random(seed)} % 100;
    endfunction

    // full 14-bit signed range
    function automatic int rand_word();
        int r;
        r = $random(seed);
        return r >>> 18;
    endfunction

    task automatic set_test(input int t, input string name, input bit nm,
                            input int gap, input int stall);
        test_name[t]    = name;
        test_new_mat[t] = nm;
        test_gap[t]     = gap;
        test_stall[t]   = stall;
    endtask

    task automatic randomize_job(input int t, input bit with_matrix);
        if (with_matrix) begin
            for (int i = 0; i < MAT_WORDS; i++) begin
                test_mat[t][i] = rand_word();
            end
        end
        for (int c = 0; c < `MV_N; c++) begin
            test_vec[t][c] = rand_word();
        end
    endtask

    // reference dot products, row r uses elements r*8 to r*8+7
    task automatic compute_expected(input int t);
        longint acc;
        for (int r = 0; r < `MV_N; r++) begin
            acc = 0;
            for (int c = 0; c < `MV_N; c++) begin
                acc += longint'(test_mat[t][r*`MV_N + c]) * longint'(test_vec[t][c]);
            end
            test_exp[t][r] = acc;
        end
    endtask

    task automatic fill_table();
        set_test(0, "identity", 1'b1, 0, 0);
        for (int i = 0; i < MAT_WORDS; i++) begin
            test_mat[0][i] = (i / `MV_N == i % `MV_N) ? 1 : 0;
        end
        test_vec[0] = '{3, -1, 4, -1, 5, -9, 2, -6};

        set_test(1, "random_extremes", 1'b1, 0, 0);
        randomize_job(1, 1'b1);
        test_mat[1][0]  = -8192;
        test_mat[1][9]  = 8191;
        test_mat[1][63] = -8192;
        test_vec[1][0]  = -8192;
        test_vec[1][1]  = 8191;
        test_vec[1][7]  = -8192;

        // matrix stays in the DUT, model reuses it
        set_test(2, "vector_only", 1'b0, 0, 0);
        test_mat[2] = test_mat[1];
        randomize_job(2, 1'b0);

        set_test(3, "output_stalls", 1'b1, 0, 60);
        randomize_job(3, 1'b1);

        set_test(4, "input_gaps", 1'b1, 40, 30);
        randomize_job(4, 1'b1);

        set_test(5, "max_magnitude", 1'b1, 0, 20);
        for (int i = 0; i < MAT_WORDS; i++) begin
            test_mat[5][i] = -8192;
        end
        test_vec[5] = '{-8192, -8192, -8192, -8192, -8192, -8192, -8192, -8192};

        set_test(6, "vector_reuse_gaps", 1'b0, 30, 30);
        test_mat[6] = test_mat[5];
        randomize_job(6, 1'b0);
        test_vec[6][3] = 8191;

        for (int t = 0; t < N_TESTS; t++) begin
            compute_expected(t);
        end
    endtask

    // one clock, then new output_ready for the job being collected
    task automatic next_cycle();
        int cur;
        @(posedge clk);
        #1;
        cur = (out_test < N_TESTS) ? out_test : N_TESTS - 1;
        output_ready = (roll() >= test_stall[cur]);
    endtask

    function automatic int word_at(input int t, input int idx);
        if (!test_new_mat[t]) begin
            return test_vec[t][idx];
        end
        if (idx < MAT_WORDS) begin
            return test_mat[t][idx];
        end
        return test_vec[t][idx - MAT_WORDS];
    endfunction

    task automatic drive_job(input int t);
        int n_words;
        int idx;
        n_words = test_new_mat[t] ? MAT_WORDS + `MV_N : `MV_N;
        idx = 0;
        while (idx < n_words) begin
            if (input_ready && outstanding != 0) begin
                $display("input_ready high while %0d results are still pending (%s)",
                         outstanding, test_name[t]);
                errors++;
            end
            if (roll() < test_gap[t]) begin
                input_valid = 1'b0;
                input_data  = mv_data_t'(rand_word());
            end else begin
                input_valid = 1'b1;
                input_data  = mv_data_t'(word_at(t, idx));
            end
            // new_matrix only counts on the first word
            new_matrix = (idx == 0) ? test_new_mat[t] : (roll() >= 50);
            if (input_valid && input_ready) begin
                idx++;
                if (idx == n_words) begin
                    outstanding += `MV_N;
                    jobs_loaded++;
                end
            end
            next_cycle();
        end
        input_valid = 1'b0;
    endtask

    initial begin : collect_results
        longint exp_val;
        int     test_errs;
        wait (reset_done);
        for (int t = 0; t < N_TESTS; t++) begin
            out_test  = t;
            test_errs = 0;
            for (int r = 0; r < `MV_N; r++) begin
                @(negedge clk);
                while (!(output_valid && output_ready)) begin
                    @(negedge clk);
                end
                if (jobs_loaded <= t) begin
                    $display("result for %s came out before its job was loaded", test_name[t]);
                    errors++;
                    test_errs++;
                end
                exp_val = test_exp[t][r];
                if (output_data != exp_val) begin
                    $display("[ERROR] %s row %0d: expected %0d, actual %0d",
                             test_name[t], r, exp_val, output_data);
                    errors++;
                    test_errs++;
                end
                outstanding--;
                checked++;
            end
            $display("test %0d %s: %s, %0d rows checked", t, test_name[t],
                     (test_errs == 0) ? "ok" : "mismatch", `MV_N);
        end
        out_test     = N_TESTS;
        collect_done = 1'b1;
    end

    initial begin
        seed         = 13;
        reset        = 1'b1;
        input_valid  = 1'b0;
        input_data   = '0;
        new_matrix   = 1'b0;
        output_ready = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        reset      = 1'b0;
        reset_done = 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            drive_job(t);
        end
        while (!collect_done) begin
            next_cycle();
        end

        // exactly eight results per job, nothing trailing
        repeat (10) begin
            next_cycle();
            if (output_valid) begin
                $display("extra result on the output after the last job");
                errors++;
            end
        end

        // bound property failures count as errors too
        if (u_dut.u_props.assert_fails != 0) begin
            $display("%0d property assertions failed", u_dut.u_props.assert_fails);
            errors += u_dut.u_props.assert_fails;
        end

        $display("summary: %0d tests, %0d results checked, %0d errors",
                 N_TESTS, checked, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/matvec8_props.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module matvec8_props
    import mv_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    input_ready,
    input logic    output_valid,
    input logic    output_ready,
    input mv_sum_t output_data
);

    // failed property count, read by the testbench at the end
    int assert_fails;

    // a refused result stays on the port unchanged
    a_hold_result: assert property (
        @(posedge clk) disable iff (reset)
        (output_valid && !output_ready) |=> (output_valid && $stable(output_data))
    ) else begin
        $error("output_data changed while output_ready was low");
        assert_fails++;
    end

    // loading and result output never overlap
    a_no_load_during_output: assert property (
        @(posedge clk) disable iff (reset)
        output_valid |-> !input_ready
    ) else begin
        $error("input_ready high while output_valid is high");
        assert_fails++;
    end

    a_idle_after_reset: assert property (
        @(posedge clk) reset |=> !output_valid
    ) else begin
        $error("output_valid high in the cycle after reset");
        assert_fails++;
    end

endmodule

bind matvec8 matvec8_props u_props (
    .clk          (clk),
    .reset        (reset),
    .input_ready  (input_ready),
    .output_valid (output_valid),
    .output_ready (output_ready),
    .output_data  (output_data)
);

// ==== rtl/matvec8.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module matvec8
    import mv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     input_valid,
    input  mv_data_t input_data,
    input  logic     new_matrix,
    input  logic     output_ready,
    output logic     input_ready,
    output logic     output_valid,
    output mv_sum_t  output_data
);

    // decode to execute
    logic [`MV_N-1:0] mat_wr_en;
    logic [`MV_N-1:0] vec_wr_en;
    mv_idx_t          wr_row;
    mv_data_t         wr_data;
    mv_idx_t          rd_row;
    logic             issue;
    logic             issue_last;

    // execute to result
    mv_prod_t         products [`MV_N];
    logic             prod_valid;
    logic             prod_last;

    // result back to decode and execute
    logic             advance;
    logic             drain_done;

    mv_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .new_matrix  (new_matrix),
        .input_data  (input_data),
        .advance     (advance),
        .drain_done  (drain_done),
        .input_ready (input_ready),
        .mat_wr_en   (mat_wr_en),
        .vec_wr_en   (vec_wr_en),
        .wr_row      (wr_row),
        .wr_data     (wr_data),
        .rd_row      (rd_row),
        .issue       (issue),
        .issue_last  (issue_last)
    );

    mv_lanes u_lanes (
        .clk        (clk),
        .reset      (reset),
        .mat_wr_en  (mat_wr_en),
        .vec_wr_en  (vec_wr_en),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .rd_row     (rd_row),
        .issue      (issue),
        .issue_last (issue_last),
        .advance    (advance),
        .products   (products),
        .prod_valid (prod_valid),
        .prod_last  (prod_last)
    );

    mv_reduce u_reduce (
        .clk          (clk),
        .reset        (reset),
        .products     (products),
        .prod_valid   (prod_valid),
        .prod_last    (prod_last),
        .output_ready (output_ready),
        .output_valid (output_valid),
        .output_data  (output_data),
        .advance      (advance),
        .drain_done   (drain_done)
    );

endmodule

// ==== rtl/mv_reduce.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module mv_reduce
    import mv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  mv_prod_t products [`MV_N],
    input  logic     prod_valid,
    input  logic     prod_last,
    input  logic     output_ready,
    output logic     output_valid,
    output mv_sum_t  output_data,
    output logic     advance,
    output logic     drain_done
);

    mv_sum_t lvl1 [`MV_N/2];
    mv_sum_t lvl2 [`MV_N/4];

    // one flag bit per tree level, msb is the output register
    logic [`MV_TREE_STAGES-1:0] vld_pipe;
    logic [`MV_TREE_STAGES-1:0] last_pipe;

    // only a refused result holds the pipeline
    assign advance = !(output_valid && !output_ready);

    assign output_valid = vld_pipe[`MV_TREE_STAGES-1];

    // row 7 leaving the output
    assign drain_done = output_valid && output_ready && last_pipe[`MV_TREE_STAGES-1];

    // adder tree, operands widen to the sum width before adding
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < `MV_N/2; i++) begin
                lvl1[i] <= products[2*i] + products[2*i+1];
            end
            for (int i = 0; i < `MV_N/4; i++) begin
                lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
            end
            output_data <= lvl2[0] + lvl2[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe  <= '0;
            last_pipe <= '0;
        end else if (advance) begin
            vld_pipe  <= {vld_pipe[`MV_TREE_STAGES-2:0], prod_valid};
            last_pipe <= {last_pipe[`MV_TREE_STAGES-2:0], prod_last};
        end
    end

endmodule

// ==== rtl/mv_lanes.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module mv_lanes
    import mv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [`MV_N-1:0] mat_wr_en,
    input  logic [`MV_N-1:0] vec_wr_en,
    input  mv_idx_t          wr_row,
    input  mv_data_t         wr_data,
    input  mv_idx_t          rd_row,
    input  logic             issue,
    input  logic             issue_last,
    input  logic             advance,
    output mv_prod_t         products [`MV_N],
    output logic             prod_valid,
    output logic             prod_last
);

    // bank c holds column c, addressed by row
    mv_data_t mat_bank [`MV_N][`MV_N];
    mv_data_t vec_reg  [`MV_N];
    mv_data_t rd_data  [`MV_N];
    logic     rd_valid;
    logic     rd_last;

    // writes land at the edge of the accepted word
    always_ff @(posedge clk) begin
        for (int c = 0; c < `MV_N; c++) begin
            if (mat_wr_en[c]) begin
                mat_bank[c][wr_row] <= wr_data;
            end
            if (vec_wr_en[c]) begin
                vec_reg[c] <= wr_data;
            end
        end
    end

    // read register then product register, both frozen on stall
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int c = 0; c < `MV_N; c++) begin
                rd_data[c]  <= mat_bank[c][rd_row];
                products[c] <= rd_data[c] * vec_reg[c];
            end
        end
    end

    // row flags follow the data through both stages
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            rd_last    <= 1'b0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else if (advance) begin
            rd_valid   <= issue;
            rd_last    <= issue_last;
            prod_valid <= rd_valid;
            prod_last  <= rd_last;
        end
    end

endmodule

// ==== rtl/mv_ctrl.sv ====
`timescale 1ns/100ps

`include "mv_params.svh"

module mv_ctrl
    import mv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             input_valid,
    input  logic             new_matrix,
    input  mv_data_t         input_data,
    input  logic             advance,
    input  logic             drain_done,
    output logic             input_ready,
    output logic [`MV_N-1:0] mat_wr_en,
    output logic [`MV_N-1:0] vec_wr_en,
    output mv_idx_t          wr_row,
    output mv_data_t         wr_data,
    output mv_idx_t          rd_row,
    output logic             issue,
    output logic             issue_last
);

    mv_state_e state;
    mv_state_e state_next;
    mv_idx_t   bank_cnt;
    mv_idx_t   row_cnt;
    logic      accept;
    logic      to_matrix;
    logic      last_bank;
    logic      last_row;

    // loading is allowed until the job starts computing
    assign input_ready = (state == ST_IDLE) || (state == ST_LOAD_MATRIX) ||
                         (state == ST_LOAD_VECTOR);
    assign accept = input_valid && input_ready;

    // first word of a job picks the path from new_matrix
    assign to_matrix = (state == ST_LOAD_MATRIX) || ((state == ST_IDLE) && new_matrix);

    assign last_bank = (bank_cnt == mv_idx_t'(`MV_N - 1));
    assign last_row  = (row_cnt == mv_idx_t'(`MV_N - 1));

    // write side, word goes straight to the selected bank or lane
    assign wr_row  = row_cnt;
    assign wr_data = input_data;

    // read side shares the row counter, loading and compute never overlap
    assign rd_row     = row_cnt;
    assign issue      = (state == ST_COMPUTE) && advance;
    assign issue_last = issue && last_row;

    // round-robin bank decode
    always_comb begin
        mat_wr_en = '0;
        vec_wr_en = '0;
        if (accept) begin
            if (to_matrix) begin
                mat_wr_en[bank_cnt] = 1'b1;
            end else begin
                vec_wr_en[bank_cnt] = 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = new_matrix ? ST_LOAD_MATRIX : ST_LOAD_VECTOR;
                end
            end
            ST_LOAD_MATRIX: begin
                // 64th word closes the matrix
                if (accept && last_bank && last_row) begin
                    state_next = ST_LOAD_VECTOR;
                end
            end
            ST_LOAD_VECTOR: begin
                if (accept && last_bank) begin
                    state_next = ST_COMPUTE;
                end
            end
            ST_COMPUTE: begin
                if (issue_last) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // wait for row 7 to leave the output
                if (drain_done) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            bank_cnt <= '0;
            row_cnt  <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                bank_cnt <= bank_cnt + 1'b1;
                // next matrix row after the last bank
                if (to_matrix && last_bank) begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
            // wraps back to row 0 after the last issue
            if (issue) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mv_pkg.sv ====
`include "mv_params.svh"

package mv_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_MATRIX,
        ST_LOAD_VECTOR,
        ST_COMPUTE,
        ST_DRAIN
    } mv_state_e;

    // input word as it arrives on input_data
    typedef logic signed [`MV_DATA_W-1:0] mv_data_t;

    // one lane product
    typedef logic signed [`MV_PROD_W-1:0] mv_prod_t;

    // row result
    typedef logic signed [`MV_SUM_W-1:0] mv_sum_t;

    // row, bank or element index
    typedef logic [`MV_IDX_W-1:0] mv_idx_t;

endpackage

// ==== rtl/mv_params.svh ====
`ifndef MV_PARAMS_SVH
`define MV_PARAMS_SVH

// lanes, matrix rows and columns
`define MV_N 8

// signed input word
`define MV_DATA_W 14

// full product of two input words
`define MV_PROD_W 28

// sum of eight products, no overflow
`define MV_SUM_W 31

// bank, row and lane index
`define MV_IDX_W 3

// adder tree levels for eight lanes
// last level doubles as the output register
`define MV_TREE_STAGES 3

`endif
